// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := audio_controller_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fails unless it reports a pass"
	@echo "  clean  remove the Verilator build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
+incdir+logic
logic/audio_pkg.sv
logic/tone_control.sv
logic/i2s_clock_gen.sv
logic/tone_voice.sv
logic/i2s_transmitter.sv
logic/audio_controller.sv
tests/tb_clock.sv
tests/audio_controller_tb.sv

// File: logic/audio_controller.sv
`timescale 1ns/100ps
`default_nettype none

module audio_controller (
    input  logic                  clk_audio,
    input  logic                  reset,
    input  audio_pkg::reg_req_t   req,
    output audio_pkg::reg_word_t  rdata,
    output logic                  audio_mclk,  // DAC master clock
    output logic                  audio_lrck,  // Word select
    output logic                  audio_sclk,  // Bit clock
    output logic                  audio_sdin   // Serial data to the DAC
);

    audio_pkg::voice_cmd_t  saw_cmd;
    audio_pkg::voice_cmd_t  square_cmd;
    audio_pkg::i2s_timing_t timing;
    audio_pkg::sample_t     saw_sample;
    audio_pkg::sample_t     square_sample;

    // ==================================================
    // Control and clocks
    // ==================================================
    tone_control u_control (
        .clk_audio  (clk_audio),
        .reset      (reset),
        .req        (req),
        .rdata      (rdata),
        .saw_cmd    (saw_cmd),
        .square_cmd (square_cmd)
    );

    i2s_clock_gen u_clock_gen (
        .clk_audio (clk_audio),
        .reset     (reset),
        .timing    (timing)
    );

    // ==================================================
    // Voices and output
    // ==================================================
    tone_voice #(.SQUARE(1'b0)) saw_voice (
        .clk_audio (clk_audio),
        .reset     (reset),
        .cmd       (saw_cmd),
        .timing    (timing),
        .sample    (saw_sample)
    );

    tone_voice #(.SQUARE(1'b1)) square_voice (
        .clk_audio (clk_audio),
        .reset     (reset),
        .cmd       (square_cmd),
        .timing    (timing),
        .sample    (square_sample)
    );

    i2s_transmitter u_transmitter (
        .clk_audio     (clk_audio),
        .reset         (reset),
        .timing        (timing),
        .saw_cmd       (saw_cmd),
        .square_cmd    (square_cmd),
        .saw_sample    (saw_sample),
        .square_sample (square_sample),
        .sdin          (audio_sdin)
    );

    assign audio_mclk = clk_audio;    // MCLK straight from the audio clock
    assign audio_lrck = timing.lrck;
    assign audio_sclk = timing.sclk;

endmodule

`default_nettype wire

// File: logic/audio_defines.svh
`ifndef AUDIO_DEFINES_SVH
`define AUDIO_DEFINES_SVH

// ==================================================
// Register map
// ==================================================
`define AUDIO_REG_SAW_FREQ         4'h0   // Sawtooth frequency in Hz
`define AUDIO_REG_SAW_DURATION     4'h1   // Sawtooth duration in ms, write starts the voice
`define AUDIO_REG_SQUARE_FREQ      4'h2   // Square frequency in Hz
`define AUDIO_REG_SQUARE_DURATION  4'h3   // Square duration in ms, write starts the voice

// ==================================================
// I2S clocking
// ==================================================
`define AUDIO_SCLK_HALF            4      // MCLK cycles per SCLK half period
`define AUDIO_LRCK_HALF            32     // SCLK periods per channel
`define AUDIO_MS_CYCLES            24576  // MCLK cycles in one millisecond

// ==================================================
// Tone synthesis
// ==================================================
// About 2^32 / 48000 per hertz
`define AUDIO_PHASE_PER_HZ         89478
`define AUDIO_SQUARE_HIGH          16'sh3FFF    // Square wave upper level
`define AUDIO_SQUARE_LOW           (-16'sh4000) // Square wave lower level
`define AUDIO_SAMPLE_BITS          16
`define AUDIO_DEFAULT_SQUARE_HZ    16'd440      // Concert A after reset

`endif

// File: logic/audio_pkg.sv
`default_nettype none

`include "audio_defines.svh"

package audio_pkg;

    typedef logic [3:0]  reg_offset_t;  // Register offset
    typedef logic [15:0] reg_word_t;    // Register data word
    typedef logic [31:0] phase_t;       // Phase accumulator and step

    // Signed PCM sample
    typedef logic signed [`AUDIO_SAMPLE_BITS-1:0] sample_t;

    // Serializer states
    typedef enum logic [1:0] {
        wait_lrck,    // Idle until the next channel starts
        delay_first,  // One SCLK of I2S delay
        transmit      // Shifting the word out
    } i2s_state_t;

    // Register port request
    typedef struct packed {
        logic        select;  // Device select
        logic        read;    // Read strobe
        logic        write;   // Write strobe
        reg_offset_t offset;  // Register offset
        reg_word_t   wdata;   // Write data
    } reg_req_t;

    // Per voice command
    typedef struct packed {
        logic      playing;  // Voice active level
        reg_word_t freq;     // Frequency in Hz
    } voice_cmd_t;

    // I2S clocks and their strobes
    typedef struct packed {
        logic sclk;         // Bit clock
        logic lrck;         // Word select
        logic sclk_fall;    // SCLK falling edge strobe
        logic lrck_edge;    // Any LRCK edge
        logic sample_tick;  // LRCK rising edge, one per stereo frame
    } i2s_timing_t;

endpackage

`default_nettype wire

// File: logic/i2s_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

`include "audio_defines.svh"

module i2s_clock_gen (
    input  logic                    clk_audio,
    input  logic                    reset,
    output audio_pkg::i2s_timing_t  timing
);

    localparam int SCLK_CNT_W = $clog2(`AUDIO_SCLK_HALF);
    localparam int LRCK_CNT_W = $clog2(`AUDIO_LRCK_HALF);

    logic [SCLK_CNT_W-1:0] sclk_cnt;   // MCLK cycles in the SCLK half period
    logic [LRCK_CNT_W-1:0] lrck_cnt;   // SCLK periods in the channel
    logic                  sclk_q;
    logic                  lrck_q;
    logic                  sclk_prev;  // Delayed copies for edge detect
    logic                  lrck_prev;

    // ==================================================
    // Dividers
    // ==================================================
    always_ff @(posedge clk_audio) begin
        if (reset) begin
            sclk_cnt  <= '0;
            lrck_cnt  <= '0;
            sclk_q    <= 1'b0;
            lrck_q    <= 1'b0;
            sclk_prev <= 1'b0;
            lrck_prev <= 1'b0;
        end else begin
            sclk_prev <= sclk_q;
            lrck_prev <= lrck_q;
            if (sclk_cnt == SCLK_CNT_W'(`AUDIO_SCLK_HALF - 1)) begin
                sclk_cnt <= '0;
                sclk_q   <= ~sclk_q;                 // SCLK = MCLK / 8
                if (!sclk_q) begin                   // Count on SCLK rising edges
                    if (lrck_cnt == LRCK_CNT_W'(`AUDIO_LRCK_HALF - 1)) begin
                        lrck_cnt <= '0;
                        lrck_q   <= ~lrck_q;         // Next channel
                    end else begin
                        lrck_cnt <= lrck_cnt + 1'b1;
                    end
                end
            end else begin
                sclk_cnt <= sclk_cnt + 1'b1;
            end
        end
    end

    assign timing.sclk        = sclk_q;
    assign timing.lrck        = lrck_q;
    assign timing.sclk_fall   = sclk_prev && !sclk_q;
    assign timing.lrck_edge   = lrck_prev ^ lrck_q;
    assign timing.sample_tick = lrck_q && !lrck_prev;  // Frame start

    // After a falling strobe SCLK stays low for a full half period
    a_sclk_low_half: assert property (
        @(posedge clk_audio) disable iff (reset)
        timing.sclk_fall |-> !timing.sclk [*`AUDIO_SCLK_HALF]
    ) else $error("sclk_fall not followed by a low SCLK half period");

endmodule

`default_nettype wire

// File: logic/i2s_transmitter.sv
`timescale 1ns/100ps
`default_nettype none

`include "audio_defines.svh"

module i2s_transmitter (
    input  logic                    clk_audio,
    input  logic                    reset,
    input  audio_pkg::i2s_timing_t  timing,
    input  audio_pkg::voice_cmd_t   saw_cmd,
    input  audio_pkg::voice_cmd_t   square_cmd,
    input  audio_pkg::sample_t      saw_sample,
    input  audio_pkg::sample_t      square_sample,
    output logic                    sdin
);

    localparam int CNT_W = $clog2(`AUDIO_SAMPLE_BITS) + 1;  // Holds 0 to 16

    logic signed [`AUDIO_SAMPLE_BITS:0] sum;       // One guard bit for the average
    audio_pkg::sample_t                 mix;       // Sample to send
    audio_pkg::i2s_state_t              state;
    logic [`AUDIO_SAMPLE_BITS-1:0]      shift_reg; // MSB goes out first
    logic [CNT_W-1:0]                   bit_cnt;   // Bits already sent

    // ==================================================
    // Mixer
    // ==================================================
    assign sum = saw_sample + square_sample;

    always_comb begin
        if (saw_cmd.playing && square_cmd.playing)
            mix = audio_pkg::sample_t'(sum >>> 1);  // Average of both voices
        else if (saw_cmd.playing)
            mix = saw_sample;
        else if (square_cmd.playing)
            mix = square_sample;
        else
            mix = '0;                               // Silence
    end

    // ==================================================
    // Serializer
    // ==================================================
    always_ff @(posedge clk_audio) begin
        if (reset) begin
            state   <= audio_pkg::wait_lrck;
            bit_cnt <= '0;
            sdin    <= 1'b0;
        end else begin
            case (state)
                audio_pkg::wait_lrck: begin
                    if (timing.lrck_edge) begin
                        shift_reg <= mix;             // Same word on both channels
                        bit_cnt   <= '0;
                        state     <= audio_pkg::delay_first;
                    end
                end
                audio_pkg::delay_first: begin
                    if (timing.sclk_fall)
                        state <= audio_pkg::transmit; // Skip one SCLK for I2S delay
                end
                audio_pkg::transmit: begin
                    if (timing.sclk_fall) begin
                        if (bit_cnt < CNT_W'(`AUDIO_SAMPLE_BITS)) begin
                            sdin      <= shift_reg[`AUDIO_SAMPLE_BITS-1];
                            shift_reg <= shift_reg << 1;
                            bit_cnt   <= bit_cnt + 1'b1;
                        end else begin
                            sdin  <= 1'b0;            // Pad rest of the channel
                            state <= audio_pkg::wait_lrck;
                        end
                    end
                end
                default: state <= audio_pkg::wait_lrck;
            endcase
        end
    end

    a_bit_cnt_range: assert property (
        @(posedge clk_audio) disable iff (reset)
        bit_cnt <= CNT_W'(`AUDIO_SAMPLE_BITS)
    ) else $error("bit counter past word length");

    // Each word finishes before the clock generator starts the next channel
    a_word_done_in_time: assert property (
        @(posedge clk_audio) disable iff (reset)
        timing.lrck_edge |-> (state == audio_pkg::wait_lrck)
    ) else $error("LRCK edge while a word is still being sent");

endmodule

`default_nettype wire

// File: logic/tone_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "audio_defines.svh"

module tone_control (
    input  logic                   clk_audio,
    input  logic                   reset,
    input  audio_pkg::reg_req_t    req,
    output audio_pkg::reg_word_t   rdata,
    output audio_pkg::voice_cmd_t  saw_cmd,
    output audio_pkg::voice_cmd_t  square_cmd
);

    localparam int PRESCALE_W = $clog2(`AUDIO_MS_CYCLES);  // 15 bits for 24575
    localparam logic [PRESCALE_W-1:0] PRESCALE_MAX = PRESCALE_W'(`AUDIO_MS_CYCLES - 1);

    audio_pkg::reg_word_t freq_reg [2];  // Index 0 sawtooth, index 1 square
    audio_pkg::reg_word_t dur_reg  [2];  // Last written durations
    logic                 wr_en;         // Write qualified by select

    assign wr_en = req.select && req.write;

    // ==================================================
    // Register file
    // ==================================================
    always_ff @(posedge clk_audio) begin
        if (reset) begin
            freq_reg[0] <= '0;                        // Sawtooth silent at 0 Hz
            freq_reg[1] <= `AUDIO_DEFAULT_SQUARE_HZ;
            dur_reg[0]  <= '0;
            dur_reg[1]  <= '0;
        end else if (wr_en) begin
            case (req.offset)
                `AUDIO_REG_SAW_FREQ:        freq_reg[0] <= req.wdata;
                `AUDIO_REG_SAW_DURATION:    dur_reg[0]  <= req.wdata;
                `AUDIO_REG_SQUARE_FREQ:     freq_reg[1] <= req.wdata;
                `AUDIO_REG_SQUARE_DURATION: dur_reg[1]  <= req.wdata;
                default: ;                                // Unmapped writes ignored
            endcase
        end
    end

    // Combinational readback, all ones when idle or unmapped
    always_comb begin
        rdata = '1;
        if (req.select && req.read) begin
            case (req.offset)
                `AUDIO_REG_SAW_FREQ:        rdata = freq_reg[0];
                `AUDIO_REG_SAW_DURATION:    rdata = dur_reg[0];
                `AUDIO_REG_SQUARE_FREQ:     rdata = freq_reg[1];
                `AUDIO_REG_SQUARE_DURATION: rdata = dur_reg[1];
                default:                    rdata = '1;
            endcase
        end
    end

    // ==================================================
    // Millisecond timers, one per voice
    // ==================================================
    for (genvar v = 0; v < 2; v++) begin : g_timer
        localparam audio_pkg::reg_offset_t DUR_OFFSET =
            (v == 0) ? `AUDIO_REG_SAW_DURATION : `AUDIO_REG_SQUARE_DURATION;

        logic [PRESCALE_W-1:0] prescaler;  // MCLK cycles within the current ms
        logic                  ms_tick;    // Last cycle of a millisecond
        audio_pkg::reg_word_t  countdown;  // Milliseconds left
        logic                  start;      // Nonzero duration write
        logic                  playing;

        assign start   = wr_en && (req.offset == DUR_OFFSET) && (req.wdata != '0);
        assign ms_tick = (prescaler == PRESCALE_MAX);

        always_ff @(posedge clk_audio) begin
            if (reset) begin
                prescaler <= '0;
                countdown <= '0;
                playing   <= 1'b0;
            end else begin
                if (ms_tick)
                    prescaler <= '0;
                else
                    prescaler <= prescaler + 1'b1;

                if (start) begin
                    countdown <= req.wdata;  // Also restarts a running voice
                    playing   <= 1'b1;
                    prescaler <= '0;         // Align ms boundary to the write
                end else if (ms_tick && countdown != '0) begin
                    countdown <= countdown - 1'b1;
                    if (countdown == 16'd1)
                        playing <= 1'b0;     // Last millisecond done
                end
            end
        end

        // A playing voice always has time left on its timer
        a_playing_has_time: assert property (
            @(posedge clk_audio) disable iff (reset)
            playing |-> (countdown != '0)
        ) else $error("voice %0d playing with zero countdown", v);
    end

    assign saw_cmd.playing    = g_timer[0].playing;
    assign saw_cmd.freq       = freq_reg[0];
    assign square_cmd.playing = g_timer[1].playing;
    assign square_cmd.freq    = freq_reg[1];

endmodule

`default_nettype wire

// File: logic/tone_voice.sv
`timescale 1ns/100ps
`default_nettype none

`include "audio_defines.svh"

module tone_voice #(
    parameter bit SQUARE = 1'b0  // 0 sawtooth, 1 square
) (
    input  logic                    clk_audio,
    input  logic                    reset,
    input  audio_pkg::voice_cmd_t   cmd,
    input  audio_pkg::i2s_timing_t  timing,
    output audio_pkg::sample_t      sample
);

    audio_pkg::phase_t  phase_inc;  // Step per frame
    audio_pkg::phase_t  phase_acc;  // Current phase
    audio_pkg::sample_t shaped;     // Waveform at the current phase

    // Registered multiply keeps it off the accumulator path
    always_ff @(posedge clk_audio) begin
        phase_inc <= audio_pkg::phase_t'(cmd.freq) *
                     audio_pkg::phase_t'(`AUDIO_PHASE_PER_HZ);
    end

    // ==================================================
    // Waveform shaping
    // ==================================================
    always_comb begin
        if (SQUARE)
            shaped = phase_acc[31] ? `AUDIO_SQUARE_HIGH : `AUDIO_SQUARE_LOW;  // 50% duty
        else
            shaped = audio_pkg::sample_t'(phase_acc[31:16] - 16'h8000);     // Offset ramp
    end

    // Accumulator runs only while the voice plays
    always_ff @(posedge clk_audio) begin
        if (reset || !cmd.playing) begin
            phase_acc <= '0;
            sample    <= '0;
        end else if (timing.sample_tick) begin
            sample    <= shaped;                   // Sample before the step
            phase_acc <= phase_acc + phase_inc;
        end
    end

    // A stopped voice goes silent
    a_silent_when_idle: assert property (
        @(posedge clk_audio) disable iff (reset)
        (!cmd.playing && $past(!cmd.playing)) |-> (sample == '0)
    ) else $error("voice sample nonzero while stopped");

endmodule

`default_nettype wire

// File: tests/audio_controller_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "audio_defines.svh"

module audio_controller_tb;

    localparam int CLK_PERIOD_NS = 8;

    typedef enum {read_back, no_check, silence, square_only, saw_only, both_voices} check_t;

    typedef struct {
        string               name;      // Shown in error lines
        audio_pkg::reg_req_t req;       // Held for one cycle
        int                  wait_ms;   // Run time before the check
        check_t              kind;
        logic [15:0]         expected;  // Readback, first word or sawtooth step
    } step_t;

    logic                 clk_audio;
    logic                 reset;
    audio_pkg::reg_req_t  req;
    audio_pkg::reg_word_t rdata;
    logic                 audio_mclk;
    logic                 audio_lrck;
    logic                 audio_sclk;
    logic                 audio_sdin;

    step_t       steps[$];
    logic        table_ready = 1'b0;
    logic [15:0] saw_hz;             // Random frequencies
    logic [15:0] square_hz;
    logic [15:0] mix_square_hz;      // Kept low for the mix run
    logic [15:0] words[$];           // Every captured word
    logic [15:0] left_words[$];      // Words sent with LRCK low, one per frame

    tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) u_clock (.clk_audio(clk_audio), .reset(reset));

    audio_controller uut (
        .clk_audio  (clk_audio),
        .reset      (reset),
        .req        (req),
        .rdata      (rdata),
        .audio_mclk (audio_mclk),
        .audio_lrck (audio_lrck),
        .audio_sclk (audio_sclk),
        .audio_sdin (audio_sdin)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] expected,
                                   input logic [15:0] actual);
        abort_run($sformatf("ERR %s: expected 0x%04h, actual 0x%04h", name, expected, actual));
    endtask

    // ==================================================
    // I2S receiver and clock ratio monitor
    // ==================================================
    logic        sclk_q     = 1'b0;
    logic        lrck_q     = 1'b0;
    logic        sclk_seen  = 1'b0;
    logic        lrck_seen  = 1'b0;
    int          mclk_cnt   = 0;    // MCLK cycles since the last SCLK rise
    int          rise_idx   = 64;   // SCLK rises since the LRCK edge, idle until the first
    logic [15:0] shift_word = '0;

    always @(posedge clk_audio) begin
        mclk_cnt = mclk_cnt + 1;
        if (audio_sclk && !sclk_q) begin                 // DAC samples on SCLK rising
            assert (!sclk_seen || mclk_cnt == 8)
                else report_mismatch("sclk period", 16'd8, 16'(mclk_cnt));
            sclk_seen = 1'b1;
            mclk_cnt  = 0;
            rise_idx  = rise_idx + 1;
            if (audio_lrck != lrck_q) begin
                assert (!lrck_seen || rise_idx == `AUDIO_LRCK_HALF)
                    else report_mismatch("lrck half period", 16'(`AUDIO_LRCK_HALF), 16'(rise_idx));
                lrck_seen = 1'b1;
                rise_idx  = 0;
            end
            lrck_q = audio_lrck;
            if (rise_idx >= 2 && rise_idx <= 17) begin   // One bit of delay, then 16 bits
                shift_word = {shift_word[14:0], audio_sdin};
                if (rise_idx == 17) begin
                    words.push_back(shift_word);
                    if (!audio_lrck)
                        left_words.push_back(shift_word);
                end
            end
        end
        sclk_q = audio_sclk;
    end

    // MCLK follows the audio clock, looked at in the middle of each phase
    always @(clk_audio) begin
        #1;
        assert (audio_mclk === clk_audio)
            else report_mismatch("mclk level", 16'(clk_audio), 16'(audio_mclk));
    end

    // ==================================================
    // Checks on the captured words
    // ==================================================
    task automatic check_silence(input step_t s);
        assert (words.size() > 0) else abort_run({"No I2S words captured in ", s.name});
        foreach (words[i]) begin
            assert (words[i] == 16'h0000) else report_mismatch(s.name, 16'h0000, words[i]);
        end
    endtask

    task automatic check_square(input step_t s);
        logic [15:0] first;
        first = '0;
        foreach (words[i]) begin
            assert (words[i] inside {16'h0000, 16'h3FFF, 16'hC000})
                else report_mismatch(s.name, words[i][15] ? 16'hC000 : 16'h3FFF, words[i]);
            if (first == '0)
                first = words[i];                        // Low level comes first
        end
        assert (first == s.expected) else report_mismatch(s.name, s.expected, first);
    endtask

    task automatic check_saw(input step_t s);
        int          first;
        logic [15:0] step_err;
        first = 0;
        while (first < left_words.size() && left_words[first] == '0)
            first++;
        assert (left_words.size() - first > 16) else abort_run({"Too few frames in ", s.name});
        assert (left_words[first] == 16'h8000)
            else report_mismatch(s.name, 16'h8000, left_words[first]);
        for (int i = first + 1; i < left_words.size(); i++) begin
            step_err = left_words[i] - left_words[i-1] - s.expected;   // Modulo 2^16
            assert (step_err inside {16'h0000, 16'h0001, 16'hFFFF})
                else report_mismatch(s.name, s.expected, left_words[i] - left_words[i-1]);
        end
    endtask

    // Average of an offset ramp and a two level square, both from phase 0
    task automatic check_mix(input step_t s);
        int          first;
        int          saw_val;
        int          square_val;
        int          model;
        logic [31:0] saw_phase;
        logic [31:0] square_phase;
        logic [15:0] err;
        first        = 0;
        saw_phase    = '0;
        square_phase = '0;
        while (first < left_words.size() && left_words[first] == '0)
            first++;
        assert (left_words.size() - first > 16) else abort_run({"Too few frames in ", s.name});
        for (int i = first; i < left_words.size(); i++) begin
            saw_val    = int'($signed(saw_phase[31:16] - 16'h8000));
            square_val = square_phase[31] ? 16383 : -16384;
            model      = (saw_val + square_val) >>> 1;  // Floor of the average
            err        = left_words[i] - 16'(model);
            assert (err inside {16'h0000, 16'h0001, 16'hFFFF})
                else report_mismatch(s.name, 16'(model), left_words[i]);
            saw_phase    = saw_phase + 32'(saw_hz) * `AUDIO_PHASE_PER_HZ;
            square_phase = square_phase + 32'(mix_square_hz) * `AUDIO_PHASE_PER_HZ;
        end
    endtask

    // ==================================================
    // Stimulus table
    // ==================================================
    function automatic audio_pkg::reg_req_t write_req(audio_pkg::reg_offset_t off,
                                                      audio_pkg::reg_word_t data);
        return '{select: 1'b1, read: 1'b0, write: 1'b1, offset: off, wdata: data};
    endfunction

    function automatic audio_pkg::reg_req_t read_req(audio_pkg::reg_offset_t off);
        return '{select: 1'b1, read: 1'b1, write: 1'b0, offset: off, wdata: 16'h0};
    endfunction

    function automatic void add_step(string name, audio_pkg::reg_req_t r, int wait_ms,
                                     check_t kind, logic [15:0] expected);
        steps.push_back('{name, r, wait_ms, kind, expected});
    endfunction

    function automatic void build_table();
        logic [15:0] saw_step;
        saw_hz        = 16'(100 + $urandom % 3900);
        square_hz     = 16'(200 + $urandom % 1800);
        mix_square_hz = 16'(50 + $urandom % 250);
        saw_step      = 16'((32'(saw_hz) * `AUDIO_PHASE_PER_HZ) >> 16);  // Top half of the step
        add_step("reset saw freq", read_req(`AUDIO_REG_SAW_FREQ), 0, read_back, 16'd0);
        add_step("reset saw duration", read_req(`AUDIO_REG_SAW_DURATION), 0, read_back, 16'd0);
        add_step("reset square freq", read_req(`AUDIO_REG_SQUARE_FREQ), 0, read_back, 16'd440);
        add_step("reset square duration", read_req(`AUDIO_REG_SQUARE_DURATION), 0,
                 read_back, 16'd0);
        add_step("unmapped read", read_req(4'h9), 0, read_back, 16'hFFFF);
        add_step("read without select", '{select: 1'b0, read: 1'b1, write: 1'b0,
                 offset: `AUDIO_REG_SQUARE_FREQ, wdata: 16'h0}, 0, read_back, 16'hFFFF);
        add_step("write saw freq", write_req(`AUDIO_REG_SAW_FREQ, saw_hz), 0, no_check, 16'h0);
        add_step("readback saw freq", read_req(`AUDIO_REG_SAW_FREQ), 0, read_back, saw_hz);
        add_step("write square freq", write_req(`AUDIO_REG_SQUARE_FREQ, square_hz), 0,
                 no_check, 16'h0);
        add_step("readback square freq", read_req(`AUDIO_REG_SQUARE_FREQ), 0,
                 read_back, square_hz);
        add_step("zero duration", write_req(`AUDIO_REG_SQUARE_DURATION, 16'd0), 1,
                 silence, 16'h0);
        add_step("square only", write_req(`AUDIO_REG_SQUARE_DURATION, 16'd2), 3,
                 square_only, 16'hC000);
        add_step("silence after square", '0, 2, silence, 16'h0);
        add_step("sawtooth only", write_req(`AUDIO_REG_SAW_DURATION, 16'd3), 2,
                 saw_only, saw_step);
        add_step("sawtooth settle", '0, 2, no_check, 16'h0);
        add_step("write mix square freq", write_req(`AUDIO_REG_SQUARE_FREQ, mix_square_hz), 0,
                 no_check, 16'h0);
        add_step("mix saw start", write_req(`AUDIO_REG_SAW_DURATION, 16'd3), 0, no_check, 16'h0);
        add_step("both voices", write_req(`AUDIO_REG_SQUARE_DURATION, 16'd3), 2,
                 both_voices, 16'h0);
        add_step("mix settle", '0, 2, no_check, 16'h0);
        add_step("silence after both", '0, 1, silence, 16'h0);
    endfunction

    // One request cycle, then the run time, then the check
    task automatic run_step(input step_t s);
        audio_pkg::reg_word_t got;
        @(negedge clk_audio);
        req = s.req;
        @(negedge clk_audio);
        got = rdata;                                  // Settled for half a cycle
        req = '0;
        words.delete();
        left_words.delete();
        repeat (s.wait_ms * `AUDIO_MS_CYCLES) @(posedge clk_audio);
        @(negedge clk_audio);
        case (s.kind)
            read_back: begin
                assert (got == s.expected) else report_mismatch(s.name, s.expected, got);
            end
            silence:     check_silence(s);
            square_only: check_square(s);
            saw_only:    check_saw(s);
            both_voices: check_mix(s);
            default: ;
        endcase
    endtask

    // ==================================================
    // Main sequence and watchdog
    // ==================================================
    initial begin
        req = '0;
        void'($urandom(32'h273a_f50f));
        build_table();
        table_ready = 1'b1;
        wait (reset === 1'b1);
        wait (reset === 1'b0);
        @(negedge clk_audio);
        assert ({audio_sdin, audio_sclk, audio_lrck} == 3'b000)
            else abort_run("I2S outputs are not low after reset");
        // Start just after an LRCK fall so back to back writes share a frame
        wait (audio_lrck == 1'b1);
        wait (audio_lrck == 1'b0);
        foreach (steps[i])
            run_step(steps[i]);
        $display("test passed");
        $finish;
    end

    initial begin
        longint limit_ns;
        wait (table_ready);
        limit_ns = 2 * `AUDIO_MS_CYCLES * CLK_PERIOD_NS;   // Reset, alignment, step overhead
        foreach (steps[i])
            limit_ns += longint'(steps[i].wait_ms) * `AUDIO_MS_CYCLES * CLK_PERIOD_NS;
        #(limit_ns);
        abort_run("Timeout: the run took longer than the stimulus table allows");
    end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 8,   // 125 MHz stand-in for the audio clock
    parameter int RESET_CYCLES = 10
) (
    output logic clk_audio,
    output logic reset
);

    initial begin
        clk_audio = 1'b0;
        forever #(PERIOD_NS / 2) clk_audio = ~clk_audio;
    end

    // Released on a falling edge like every other DUT input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_audio);
        @(negedge clk_audio);
        reset = 1'b0;
    end

endmodule

`default_nettype wire
